/* sources.f */
sigdel_pkg.sv
sigdel_clkdiv.sv
sinc_filter.sv
level_select.sv
pwm_gen.sv
sigdel_top.sv
tb_sigdel.sv

/* Bender.yml */
package:
  name: sigdel

dependencies: {}

sources:
  # Design
  - sigdel_pkg.sv
  - sigdel_clkdiv.sv
  - sinc_filter.sv
  - level_select.sv
  - pwm_gen.sv
  - sigdel_top.sv

  # Testbench
  - target: test
    files:
      - tb_sigdel.sv

/* tb_sigdel.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sigdel import sigdel_pkg::*; ();

  localparam int CLK_DIV    = 4;
  localparam int OSR        = 16;
  localparam int LOG2_OSR   = $clog2(OSR);
  localparam int WINDOW     = CLK_DIV * OSR;    // Clocks per output
  localparam int PWM_PERIOD = 1 << LEVEL_W;
  localparam int LEVEL_TOP  = (1 << LEVEL_W) - 1;
  localparam int NUM_ROWS   = 7;
  localparam int SKIP_WIN   = 4;                // Windows left to settle
  localparam int CHECK_WIN  = 2;
  localparam int TIMEOUT    = NUM_ROWS * ((SKIP_WIN + CHECK_WIN) * WINDOW + 2 * PWM_PERIOD) * 2;

  logic   clk;
  logic   rst_n;
  logic   din;
  order_t order_sel;
  acc_t   sinc1_out;
  acc_t   sinc2_out;
  acc_t   sinc3_out;
  logic   out_valid;
  level_t level;
  logic   pwm_out;

  // Stimulus table
  string          row_name  [NUM_ROWS];
  logic [OSR-1:0] row_pat   [NUM_ROWS];   // Bit i is sample i
  order_t         row_order [NUM_ROWS];
  bit             row_rand  [NUM_ROWS];   // Pattern replaced by $random

  logic [OSR-1:0]      cur_pattern;       // Pattern now on din
  logic [LOG2_OSR-1:0] slot;              // Sample slot in the pattern
  int                  hold_cnt;          // Clocks spent in this slot
  int                  cycle_cnt;
  int                  last_valid;        // Cycle of previous out_valid
  int                  error_cnt;
  int                  check_cnt;
  integer              seed;

  sigdel_top #(
    .CLK_DIV (CLK_DIV),
    .OSR     (OSR)
  ) i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .din       (din),
    .order_sel (order_sel),
    .sinc1_out (sinc1_out),
    .sinc2_out (sinc2_out),
    .sinc3_out (sinc3_out),
    .out_valid (out_valid),
    .level     (level),
    .pwm_out   (pwm_out)
  );

  ////////////////////////////////////////////////////////////
  // Clock, bit stream and watchdog
  ////////////////////////////////////////////////////////////
  initial clk = 1'b0;
  always #2 clk = ~clk;                   // 4 ns period

  // Each pattern bit held for one sample period
  always @(posedge clk) begin
    if (hold_cnt == CLK_DIV - 1) begin
      hold_cnt <= 0;
      slot     <= slot + 1'b1;            // Wraps after OSR slots
    end else begin
      hold_cnt <= hold_cnt + 1;
    end
    din <= cur_pattern[slot];
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // Output rate spacing, checked on every pulse
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (last_valid >= 0) begin
        check_value("valid_spacing", WINDOW, cycle_cnt - last_valid);
      end
      last_valid = cycle_cnt;
    end
  end

  ////////////////////////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////////////////////////
  task automatic check_value(string test, int expected, logic [31:0] actual);
    check_cnt++;
    if (actual !== expected) begin
      error_cnt++;
      $display("[ERROR] %s: expected %0d, actual %0d", test, expected, actual);
    end
  endtask

  function automatic int count_ones(logic [OSR-1:0] pat);
    int n;
    int i;
    n = 0;
    for (i = 0; i < OSR; i++) begin
      n = n + int'(pat[i]);
    end
    return n;
  endfunction

  // k ones per window give k * OSR^(order-1)
  function automatic int expected_sinc(int k, int ord);
    int val;
    val = k;
    repeat (ord - 1) val = val * OSR;
    return val;
  endfunction

  function automatic int expected_level(int k, int ord);
    int val;
    int sh;
    val = expected_sinc(k, ord);
    sh  = LEVEL_W - ord * LOG2_OSR;       // Negative means right shift
    if (sh >= 0) begin
      val = val << sh;
    end else begin
      val = val >> (-sh);
    end
    if (val > LEVEL_TOP) begin
      val = LEVEL_TOP;                    // Clip at full scale
    end
    return val;
  endfunction

  task automatic load_row(int idx, string name, logic [OSR-1:0] pat,
                          order_t ord, bit rnd);
    row_name[idx]  = name;
    row_pat[idx]   = pat;
    row_order[idx] = ord;
    row_rand[idx]  = rnd;
  endtask

  task automatic fill_table();
    load_row(0, "all_zero",   16'h0000, order_t'(1), 1'b0);
    load_row(1, "all_one",    16'hFFFF, order_t'(2), 1'b0);  // Saturates
    load_row(2, "alt_0101",   16'hAAAA, order_t'(3), 1'b0);
    load_row(3, "one_in_4",   16'h8888, order_t'(1), 1'b0);
    load_row(4, "three_in_4", 16'hEEEE, order_t'(2), 1'b0);
    load_row(5, "one_in_8",   16'h8080, order_t'(3), 1'b0);
    load_row(6, "random",     16'h0000, order_t'(1), 1'b1);
  endtask

  task automatic wait_valid();
    do @(negedge clk); while (out_valid !== 1'b1);
  endtask

  task automatic check_reset_state();
    check_value("reset out_valid", 0, out_valid);
    check_value("reset pwm_out", 0, pwm_out);
    check_value("reset level", 0, level);
    check_value("reset sinc1", 0, sinc1_out);
    check_value("reset sinc2", 0, sinc2_out);
    check_value("reset sinc3", 0, sinc3_out);
  endtask

  ////////////////////////////////////////////////////////////
  // One table row
  ////////////////////////////////////////////////////////////
  task automatic run_row(int r);
    logic [OSR-1:0] pat;
    int             k;
    int             ord;
    int             exp_lvl;
    int             high_cnt;
    int             i;
    pat = row_pat[r];
    if (row_rand[r]) begin
      pat = $random(seed);                // Low bits only
    end
    k       = count_ones(pat);
    ord     = (row_order[r] == 0) ? 1 : int'(row_order[r]);   // 0 acts as 1
    exp_lvl = expected_level(k, ord);
    $display("Row %s: pattern %h, k %0d, order %0d", row_name[r], pat, k, ord);

    @(posedge clk);
    cur_pattern <= pat;
    order_sel   <= row_order[r];

    for (i = 0; i < SKIP_WIN; i++) begin
      wait_valid();                       // Combs still hold old samples
    end
    for (i = 0; i < CHECK_WIN; i++) begin
      wait_valid();
      check_value($sformatf("%s sinc1", row_name[r]), expected_sinc(k, 1), sinc1_out);
      check_value($sformatf("%s sinc2", row_name[r]), expected_sinc(k, 2), sinc2_out);
      check_value($sformatf("%s sinc3", row_name[r]), expected_sinc(k, 3), sinc3_out);
      @(negedge clk);                     // Level loads a clock later
      check_value($sformatf("%s level", row_name[r]), exp_lvl, level);
    end

    // Let the PWM latch take the settled level
    repeat (PWM_PERIOD) @(negedge clk);
    high_cnt = 0;
    repeat (PWM_PERIOD) begin
      @(negedge clk);
      if (pwm_out) begin
        high_cnt++;
      end
    end
    check_value($sformatf("%s pwm_high", row_name[r]), exp_lvl, high_cnt);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////
  initial begin
    int r;
    rst_n       = 1'b0;
    din         = 1'b0;
    order_sel   = order_t'(1);
    cur_pattern = '0;
    slot        = '0;
    hold_cnt    = 0;
    cycle_cnt   = 0;
    last_valid  = -1;
    error_cnt   = 0;
    check_cnt   = 0;
    seed        = 98669;
    fill_table();

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_reset_state();                  // Well before the first strobe

    for (r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end

    $display("Checks run: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sigdel_top.sv */
`timescale 1ns/1ps
`default_nettype none

// Sigma-delta decimation subsystem
// Bit stream in, three CIC results, scaled level and PWM out
module sigdel_top import sigdel_pkg::*; #(
  parameter int CLK_DIV = 4,    // Clocks per sample
  parameter int OSR     = 16    // Samples per output, power of two
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   din,           // Modulator stream
  input  order_t order_sel,     // Filter feeding the level
  output acc_t   sinc1_out,
  output acc_t   sinc2_out,
  output acc_t   sinc3_out,
  output logic   out_valid,     // New results this clock
  output level_t level,
  output logic   pwm_out
);

  logic fs_en;                  // Sample strobe
  logic bw_en;                  // Output rate strobe
  logic sinc3_valid;            // Shared result timing

  ////////////////////////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////////////////////////
  sigdel_clkdiv #(
    .CLK_DIV (CLK_DIV),
    .OSR     (OSR)
  ) i_clkdiv (
    .clk   (clk),
    .rst_n (rst_n),
    .fs_en (fs_en),
    .bw_en (bw_en)
  );

  ////////////////////////////////////////////////////////////
  // Filters
  ////////////////////////////////////////////////////////////

  // All three share strobes so results update together
  sinc_filter #(
    .ORDER (1),
    .OSR   (OSR)
  ) i_sinc1 (
    .clk    (clk),
    .rst_n  (rst_n),
    .din    (din),
    .fs_en  (fs_en),
    .bw_en  (bw_en),
    .result (sinc1_out),
    .valid  ()                  // Same timing as i_sinc3
  );

  sinc_filter #(
    .ORDER (2),
    .OSR   (OSR)
  ) i_sinc2 (
    .clk    (clk),
    .rst_n  (rst_n),
    .din    (din),
    .fs_en  (fs_en),
    .bw_en  (bw_en),
    .result (sinc2_out),
    .valid  ()                  // Same timing as i_sinc3
  );

  sinc_filter #(
    .ORDER (3),
    .OSR   (OSR)
  ) i_sinc3 (
    .clk    (clk),
    .rst_n  (rst_n),
    .din    (din),
    .fs_en  (fs_en),
    .bw_en  (bw_en),
    .result (sinc3_out),
    .valid  (sinc3_valid)
  );

  assign out_valid = sinc3_valid;

  ////////////////////////////////////////////////////////////
  // Level and PWM
  ////////////////////////////////////////////////////////////
  level_select #(
    .OSR (OSR)
  ) i_level (
    .clk          (clk),
    .rst_n        (rst_n),
    .order_sel    (order_sel),
    .sinc1_result (sinc1_out),
    .sinc2_result (sinc2_out),
    .sinc3_result (sinc3_out),
    .result_valid (sinc3_valid),
    .level        (level)
  );

  pwm_gen i_pwm (
    .clk     (clk),
    .rst_n   (rst_n),
    .duty    (level),           // Level read back as duty
    .pwm_out (pwm_out)
  );

endmodule

`default_nettype wire

/* pwm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// Pulse width output as a crude DAC
// Period is 2^LEVEL_W clocks
module pwm_gen import sigdel_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  level_t duty,          // Requested high time in clocks
  output logic   pwm_out
);

  level_t cnt;                  // Free running period counter
  level_t duty_q;               // Duty for the current period

  ////////////////////////////////////////////////////////////
  // Period counter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;        // Natural wrap
    end
  end

  ////////////////////////////////////////////////////////////
  // Duty latch and compare
  ////////////////////////////////////////////////////////////

  // Duty only changes at period start
  // so a period never mixes two levels
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      duty_q <= '0;
    end else if (cnt == '0) begin
      duty_q <= duty;
    end
  end

  // High while counter below duty
  // 0 stays low, full scale is low one clock per period
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pwm_out <= 1'b0;
    end else begin
      pwm_out <= (cnt < duty_q);
    end
  end

endmodule

`default_nettype wire

/* level_select.sv */
`timescale 1ns/1ps
`default_nettype none

module level_select import sigdel_pkg::*; #(
  parameter int OSR = 16        // Sets the gain of each filter order
) (
  input  logic   clk,
  input  logic   rst_n,
  input  order_t order_sel,     // 0 acts as order 1
  input  acc_t   sinc1_result,
  input  acc_t   sinc2_result,
  input  acc_t   sinc3_result,
  input  logic   result_valid,  // New results present this clock
  output level_t level          // Scaled and saturated level
);

  localparam int LOG2_OSR = $clog2(OSR);
  localparam int SCALE_W  = ACC_W + LEVEL_W;  // Room for the widest left shift

  // Shift per order, positive means left
  localparam int SH1 = LEVEL_W - 1 * LOG2_OSR;
  localparam int SH2 = LEVEL_W - 2 * LOG2_OSR;
  localparam int SH3 = LEVEL_W - 3 * LOG2_OSR;

  // Scale a filter value to the level range and clip at full scale
  function automatic level_t scale_sat(acc_t val, int sh);
    logic [SCALE_W-1:0] wide;
    wide = SCALE_W'(val);
    if (sh >= 0) begin
      wide = wide << sh;
    end else begin
      wide = wide >> (-sh);
    end
    if (wide > SCALE_W'(LEVEL_MAX)) begin
      return LEVEL_MAX;                       // Saturate
    end
    return level_t'(wide);
  endfunction

  level_t lvl1;                 // Order 1 scaled
  level_t lvl2;                 // Order 2 scaled
  level_t lvl3;                 // Order 3 scaled
  level_t lvl_sel;

  // Constant shifts per order
  assign lvl1 = scale_sat(sinc1_result, SH1);
  assign lvl2 = scale_sat(sinc2_result, SH2);
  assign lvl3 = scale_sat(sinc3_result, SH3);

  always_comb begin
    case (order_sel)
      order_t'(2): lvl_sel = lvl2;
      order_t'(3): lvl_sel = lvl3;
      default:     lvl_sel = lvl1;            // Orders 0 and 1
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level <= '0;
    end else if (result_valid) begin
      level <= lvl_sel;                       // Held until next window
    end
  end

endmodule

`default_nettype wire

/* sinc_filter.sv */
`timescale 1ns/1ps
`default_nettype none

// CIC decimator of selectable order
// Integrators run at the sample rate, combs at the output rate
module sinc_filter import sigdel_pkg::*; #(
  parameter int ORDER = 3,      // Number of integrator / comb pairs
  parameter int OSR   = 16      // Decimation ratio
) (
  input  logic clk,
  input  logic rst_n,
  input  logic din,             // Modulator bit stream
  input  logic fs_en,           // Sample strobe
  input  logic bw_en,           // Output rate strobe
  output acc_t result,          // Decimated filter value
  output logic valid            // One clock with each new result
);

  localparam int LOG2_OSR = $clog2(OSR);

  // Largest output is OSR^ORDER
  localparam int NEED_W = ORDER * LOG2_OSR + 1;

  ////////////////////////////////////////////////////////////
  // Elaboration checks on the word width
  ////////////////////////////////////////////////////////////
  generate
    if (ORDER < 1) begin : g_order_err
      $error("sinc_filter needs ORDER of at least 1");
    end
    if (NEED_W > ACC_W) begin : g_width_err
      $error("sinc_filter ACC_W too narrow for this ORDER and OSR");
    end
  endgenerate

  acc_t integ     [ORDER];      // Integrator state
  acc_t integ_in  [ORDER];      // Integrator stage inputs
  acc_t comb_in   [ORDER];      // Comb stage inputs
  acc_t comb_dly  [ORDER];      // Comb input from previous window
  acc_t comb_diff [ORDER];      // Comb stage outputs

  genvar g;

  ////////////////////////////////////////////////////////////
  // Integrator chain
  ////////////////////////////////////////////////////////////
  generate
    for (g = 0; g < ORDER; g++) begin : g_integ

      if (g == 0) begin : g_first
        assign integ_in[g] = acc_t'(din);     // Stream bit as 0 or 1
      end else begin : g_chain
        assign integ_in[g] = integ[g-1];      // Previous stage state
      end

      // Adds on each sample strobe
      // Overflow wraps mod 2^ACC_W and cancels in the combs
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          integ[g] <= '0;
        end else if (fs_en) begin
          integ[g] <= integ[g] + integ_in[g];
        end
      end

    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // Comb chain at the output rate
  ////////////////////////////////////////////////////////////
  generate
    for (g = 0; g < ORDER; g++) begin : g_comb

      if (g == 0) begin : g_first
        assign comb_in[g] = integ[ORDER-1];   // Last integrator, decimated
      end else begin : g_chain
        assign comb_in[g] = comb_diff[g-1];
      end

      // Difference against the value one window back
      assign comb_diff[g] = comb_in[g] - comb_dly[g];

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          comb_dly[g] <= '0;
        end else if (bw_en) begin
          comb_dly[g] <= comb_in[g];          // Store for next window
        end
      end

    end
  endgenerate

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////

  // Loads on the edge that samples bw_en
  // Integrator state taken here excludes the sample of this same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result <= '0;
      valid  <= 1'b0;
    end else begin
      valid <= bw_en;                         // Single clock pulse
      if (bw_en) begin
        result <= comb_diff[ORDER-1];
      end
    end
  end

endmodule

`default_nettype wire

/* sigdel_clkdiv.sv */
`timescale 1ns/1ps
`default_nettype none

module sigdel_clkdiv #(
  parameter int CLK_DIV = 4,    // Clocks per sample strobe
  parameter int OSR     = 16    // Samples per output window
) (
  input  logic clk,
  input  logic rst_n,
  output logic fs_en,           // Sample strobe
  output logic bw_en            // Output rate strobe
);

  localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam int OSR_W = (OSR > 1) ? $clog2(OSR) : 1;

  logic [DIV_W-1:0] div_cnt;    // Clock down counter
  logic [OSR_W-1:0] fs_cnt;     // Samples seen in this window
  logic             div_wrap;   // Divider at terminal count
  logic             last_fs;    // Next strobe closes the window

  assign div_wrap = (div_cnt == '0);
  assign last_fs  = (fs_cnt == OSR_W'(OSR - 1));

  ////////////////////////////////////////////////////////////
  // Sample rate divider
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= DIV_W'(CLK_DIV - 1);
      fs_en   <= 1'b0;
    end else begin
      fs_en <= div_wrap;        // Lands CLK_DIV clocks out of reset
      if (div_wrap) begin
        div_cnt <= DIV_W'(CLK_DIV - 1);   // Reload
      end else begin
        div_cnt <= div_cnt - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Output rate window
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fs_cnt <= '0;
      bw_en  <= 1'b0;
    end else begin
      bw_en <= div_wrap && last_fs;       // Same clock as OSR-th fs_en
      if (div_wrap) begin
        fs_cnt <= last_fs ? '0 : fs_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* sigdel_pkg.sv */
`default_nettype none

package sigdel_pkg;

  ////////////////////////////////////////////////////////////
  // Word widths
  ////////////////////////////////////////////////////////////

  // Integrator and comb word
  // Holds OSR^3 for OSR up to 16 with headroom to spare
  parameter int ACC_W   = 16;

  parameter int LEVEL_W = 8;    // Scaled level and PWM counter
  parameter int ORDER_W = 2;    // Enough for orders 1..3

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  // Accumulator value or filter result
  typedef logic [ACC_W-1:0]   acc_t;

  // Output level and PWM duty
  typedef logic [LEVEL_W-1:0] level_t;

  // Filter order select
  // Value 0 behaves as order 1
  typedef logic [ORDER_W-1:0] order_t;

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  // Full scale level used as saturation ceiling
  parameter level_t LEVEL_MAX = '1;

endpackage

`default_nettype wire
